/* rtl/marker_pkg.sv */
`default_nettype none

package marker_pkg;

	// bits per word slot on the serial line
	localparam int marker_width = 8;

	// fixed marker sequence, sent msb first
	localparam logic [marker_width-1:0] marker_first  = 8'b11110000;
	localparam logic [marker_width-1:0] marker_second = 8'b10000001;
	localparam logic [marker_width-1:0] marker_third  = 8'b10001000;
	localparam logic [marker_width-1:0] marker_fourth = 8'b10101010;

	// idle slots carry this
	localparam logic [marker_width-1:0] marker_idle = '0;

	// which marker goes out on the next firing
	typedef enum logic [1:0] {
		token_first  = 2'd0,
		token_second = 2'd1,
		token_third  = 2'd2,
		token_fourth = 2'd3
	} marker_token_e;

	// sequencer to serializer, one load per slot
	typedef struct packed {
		// one-cycle pulse, word and sync valid
		logic load;
		// level to show for this slot
		logic sync;
		// zero for an idle slot
		logic [marker_width-1:0] word;
	} marker_load_t;

endpackage

`default_nettype wire

/* rtl/slot_pkg.sv */
`default_nettype none

package slot_pkg;

	// trigger source select
	typedef enum logic {
		mode_external = 1'b0,
		mode_self     = 1'b1
	} trig_mode_e;

	// slot timing from the timer to the sequencer
	typedef struct packed {
		// one cycle before each slot boundary
		logic slot_strobe;
		// only ever together with slot_strobe
		logic self_fire;
	} slot_tick_t;

endpackage

`default_nettype wire

/* rtl/trig_input_conditioner.sv */
`timescale 1ns/1ns
`default_nettype none

module trig_input_conditioner (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_in,
	input  logic trigger_taken,
	output logic trigger_pending
);

	// two sync stages then the edge register
	logic sync_meta;
	logic sync_stable;
	logic sync_prev;
	logic rise;

	assign rise = sync_stable & ~sync_prev;

	always_ff @(posedge clock) begin
		if (reset1) begin
			sync_meta <= 1'b0;
			sync_stable <= 1'b0;
			sync_prev <= 1'b0;
		end else begin
			sync_meta <= trigger_in;
			sync_stable <= sync_meta;
			sync_prev <= sync_stable;
		end
	end

	// one request at a time
	// an edge seen while pending just merges into it
	// the sequencer's take always wins over a new edge
	always_ff @(posedge clock) begin
		if (reset1) begin
			trigger_pending <= 1'b0;
		end else if (trigger_taken) begin
			trigger_pending <= 1'b0;
		end else if (rise) begin
			trigger_pending <= 1'b1;
		end
	end

	// pending follows the input by the three register stages
	a_pending_latency : assert property (
		@(posedge clock) disable iff (reset1)
		$rose(trigger_pending) |-> $past(trigger_in, 3)
	) else $error("trigger_pending rose without trigger_in high three cycles before");

endmodule

`default_nettype wire

/* rtl/slot_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module slot_timer #(
	parameter int interval_bits = 24
) (
	input  logic clock,
	input  logic reset1,
	output slot_pkg::slot_tick_t tick
);

	// position of the bit now on the serial line
	logic [2:0] bit_pos;

	// slots since the last self fire
	logic [interval_bits-1:0] slot_count;

	logic strobe;
	logic wrap;

	// strobe at position 6 puts the load at 7 and the frame at 0
	assign strobe = (bit_pos == 3'd6);
	assign wrap = &slot_count;

	always_ff @(posedge clock) begin
		if (reset1) begin
			bit_pos <= 3'd0;
		end else begin
			bit_pos <= bit_pos + 3'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset1) begin
			slot_count <= '0;
		end else if (strobe) begin
			slot_count <= slot_count + 1'b1;
		end
	end

	assign tick.slot_strobe = strobe;
	assign tick.self_fire = strobe & wrap;

endmodule

`default_nettype wire

/* rtl/marker_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module marker_sequencer (
	input  logic clock,
	input  logic reset1,
	input  slot_pkg::trig_mode_e mode,
	input  slot_pkg::slot_tick_t tick,
	input  logic trigger_pending,
	output logic trigger_taken,
	output marker_pkg::marker_load_t marker
);

	import marker_pkg::*;
	import slot_pkg::*;

	marker_token_e token;

	// level between first and second marker
	logic sync_state;

	logic fire;
	logic fire_first;
	logic fire_second;
	logic [marker_width-1:0] token_word;

	// self mode ignores the external request entirely
	assign fire = tick.slot_strobe &
		((mode == mode_self) ? tick.self_fire : trigger_pending);

	assign fire_first = fire && (token == token_first);
	assign fire_second = fire && (token == token_second);

	always_comb begin
		case (token)
			token_first:  token_word = marker_first;
			token_second: token_word = marker_second;
			token_third:  token_word = marker_third;
			default:      token_word = marker_fourth;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset1) begin
			token <= token_first;
			sync_state <= 1'b0;
			trigger_taken <= 1'b0;
			marker <= '0;
		end else begin
			trigger_taken <= fire;
			marker.load <= tick.slot_strobe;
			if (fire) begin
				token <= marker_token_e'(token + 2'd1);
			end
			if (fire_first) begin
				sync_state <= 1'b1;
			end else if (fire_second) begin
				sync_state <= 1'b0;
			end
			if (tick.slot_strobe) begin
				// sync still shows high in the slot carrying the second marker
				marker.sync <= fire_first | sync_state;
				marker.word <= fire ? token_word : marker_idle;
			end
		end
	end

	// a self fire off the slot boundary would be lost here
	a_fire_on_strobe : assert property (
		@(posedge clock) disable iff (reset1)
		tick.self_fire |-> tick.slot_strobe
	) else $error("self_fire outside a slot strobe");

	// sync is up exactly while the second marker is next
	a_sync_matches_token : assert property (
		@(posedge clock) disable iff (reset1)
		sync_state == (token == token_second)
	) else $error("sync state out of step with the marker token");

endmodule

`default_nettype wire

/* rtl/word_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module word_serializer (
	input  logic clock,
	input  logic reset1,
	input  marker_pkg::marker_load_t marker,
	output logic serial_out,
	output logic frame,
	output logic sync,
	output logic [marker_pkg::marker_width-1:0] status_word
);

	import marker_pkg::*;

	logic [marker_width-1:0] shift_reg;

	// msb first, zero fill behind it
	assign serial_out = shift_reg[marker_width-1];

	always_ff @(posedge clock) begin
		if (reset1) begin
			shift_reg <= '0;
		end else if (marker.load) begin
			shift_reg <= marker.word;
		end else begin
			shift_reg <= {shift_reg[marker_width-2:0], 1'b0};
		end
	end

	// frame lines up with the msb
	always_ff @(posedge clock) begin
		if (reset1) begin
			frame <= 1'b0;
			sync <= 1'b0;
			status_word <= '0;
		end else begin
			frame <= marker.load;
			if (marker.load) begin
				sync <= marker.sync;
				status_word <= marker.word;
			end
		end
	end

	// slots tile with no gap or overlap
	a_load_spacing : assert property (
		@(posedge clock) disable iff (reset1)
		marker.load |=> (!marker.load)[*(marker_width-1)] ##1 marker.load
	) else $error("serializer loads not %0d cycles apart", marker_width);

endmodule

`default_nettype wire

/* rtl/trigger_marker_top.sv */
`timescale 1ns/1ns
`default_nettype none

module trigger_marker_top #(
	// self-trigger period is 2**interval_bits slots
	parameter int interval_bits = 24
) (
	input  logic clock,
	input  logic reset1,
	input  logic trigger_in,
	input  slot_pkg::trig_mode_e mode,
	output logic serial_out,
	output logic frame,
	output logic sync,
	output logic [marker_pkg::marker_width-1:0] status_word
);

	import marker_pkg::*;
	import slot_pkg::*;

	logic trigger_pending;
	logic trigger_taken;
	slot_tick_t tick;
	marker_load_t marker;

	trig_input_conditioner conditioner (
		.clock           (clock),
		.reset1          (reset1),
		.trigger_in      (trigger_in),
		.trigger_taken   (trigger_taken),
		.trigger_pending (trigger_pending)
	);

	slot_timer #(
		.interval_bits (interval_bits)
	) timer (
		.clock  (clock),
		.reset1 (reset1),
		.tick   (tick)
	);

	marker_sequencer sequencer (
		.clock           (clock),
		.reset1          (reset1),
		.mode            (mode),
		.tick            (tick),
		.trigger_pending (trigger_pending),
		.trigger_taken   (trigger_taken),
		.marker          (marker)
	);

	// stands in for the output serializer primitives
	word_serializer serializer (
		.clock       (clock),
		.reset1      (reset1),
		.marker      (marker),
		.serial_out  (serial_out),
		.frame       (frame),
		.sync        (sync),
		.status_word (status_word)
	);

endmodule

`default_nettype wire

/* sim/trigger_marker_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module trigger_marker_tb;

	import slot_pkg::*;

	localparam int interval_bits = 4;
	// 2**interval_bits slots of 8 clocks each
	localparam int self_period = (1 << interval_bits) * 8;
	localparam int word_timeout = 24;

	logic clock;
	logic reset1;
	logic trigger_in;
	trig_mode_e mode;
	logic serial_out;
	logic frame;
	logic sync;
	logic [7:0] status_word;

	int seed = 32'he78e;
	int cycle;
	int error_count;
	int timeout_count;
	int check_count;
	int rx_error_count;
	int rx_check_count;
	int next_token;
	int rd_ptr;

	// words completed by the receiver in arrival order
	logic [7:0] word_q[$];
	int cycle_q[$];

	logic [7:0] rx_shift;
	int rx_bits;
	logic rx_sync;
	int rx_cycle;
	logic sync_expect;

	trigger_marker_top #(
		.interval_bits (interval_bits)
	) DUT (
		.clock       (clock),
		.reset1      (reset1),
		.trigger_in  (trigger_in),
		.mode        (mode),
		.serial_out  (serial_out),
		.frame       (frame),
		.sync        (sync),
		.status_word (status_word)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// the four marker words in sequence order
	function automatic logic [7:0] marker_pattern(input int idx);
		case (idx)
			0: marker_pattern = 8'b11110000;
			1: marker_pattern = 8'b10000001;
			2: marker_pattern = 8'b10001000;
			default: marker_pattern = 8'b10101010;
		endcase
	endfunction

	// serial receiver sampling at the falling edge
	always @(negedge clock) begin
		if (reset1) begin
			rx_bits = 0;
			sync_expect = 1'b0;
		end else if (frame) begin
			if (rx_bits != 0) begin
				$display("frame arrived after only %0d bits of the previous word", rx_bits);
				rx_error_count++;
			end
			rx_shift = {7'b0, serial_out};
			rx_bits = 1;
			rx_sync = sync;
			rx_cycle = cycle;
		end else if (rx_bits > 0) begin
			rx_shift = {rx_shift[6:0], serial_out};
			rx_bits++;
		end
		if (rx_bits == 8) begin
			rx_check_count++;
			if (rx_shift !== status_word) begin
				$display("ERROR status_word: expected %h, got %h", rx_shift, status_word);
				rx_error_count++;
			end
			// sync is high from the first marker through the second
			if (rx_shift == marker_pattern(0)) begin
				sync_expect = 1'b1;
			end
			if (rx_sync !== sync_expect) begin
				$display("ERROR sync: expected %h, got %h", sync_expect, rx_sync);
				rx_error_count++;
			end
			if (rx_shift == marker_pattern(1)) begin
				sync_expect = 1'b0;
			end
			word_q.push_back(rx_shift);
			cycle_q.push_back(rx_cycle);
			rx_bits = 0;
		end
	end

	task automatic pop_word(output logic [7:0] w, output int c);
		begin
			w = word_q[rd_ptr];
			c = cycle_q[rd_ptr];
			rd_ptr++;
		end
	endtask

	task automatic next_word(output logic [7:0] w, output int c, output bit ok);
		int waited;
		begin
			waited = 0;
			while (rd_ptr >= word_q.size() && waited < word_timeout) begin
				@(negedge clock);
				waited++;
			end
			if (rd_ptr < word_q.size()) begin
				pop_word(w, c);
				ok = 1'b1;
			end else begin
				$display("timeout: no frame word completed within %0d cycles", word_timeout);
				timeout_count++;
				w = 8'h00;
				c = 0;
				ok = 1'b0;
			end
		end
	endtask

	// everything received so far must be idle
	task automatic drain_idle();
		logic [7:0] w;
		int c;
		begin
			while (rd_ptr < word_q.size()) begin
				pop_word(w, c);
				check_count++;
				if (w !== 8'h00) begin
					$display("ERROR status_word: expected %h, got %h", 8'h00, w);
					error_count++;
				end
			end
		end
	endtask

	task automatic expect_idle(input int n_words);
		logic [7:0] w;
		int c;
		bit ok;
		int i;
		begin
			for (i = 0; i < n_words; i++) begin
				next_word(w, c, ok);
				check_count++;
				if (ok && w !== 8'h00) begin
					$display("ERROR status_word: expected %h, got %h", 8'h00, w);
					error_count++;
				end
			end
		end
	endtask

	// idle words may come first and the first nonzero one must match
	task automatic expect_marker(input logic [7:0] expected, input int max_words);
		logic [7:0] w;
		int c;
		bit ok;
		bit seen;
		int n;
		begin
			seen = 1'b0;
			n = 0;
			while (!seen && n < max_words) begin
				next_word(w, c, ok);
				n++;
				if (!ok) begin
					n = max_words;
				end else if (w !== 8'h00) begin
					seen = 1'b1;
					check_count++;
					if (w !== expected) begin
						$display("ERROR status_word: expected %h, got %h", expected, w);
						error_count++;
					end
				end
			end
			if (!seen) begin
				$display("no marker word arrived within %0d slots", max_words);
				error_count++;
			end
		end
	endtask

	task automatic wait_for_frame();
		int waited;
		begin
			waited = 0;
			@(negedge clock);
			while (frame !== 1'b1 && waited < 16) begin
				@(negedge clock);
				waited++;
			end
			if (frame !== 1'b1) begin
				$display("timeout: frame did not go high within 16 cycles");
				timeout_count++;
			end
		end
	endtask

	task automatic check_idle_after_reset();
		int i;
		begin
			for (i = 0; i < 48; i++) begin
				@(negedge clock);
				check_count++;
				if (serial_out !== 1'b0) begin
					$display("ERROR serial_out: expected %h, got %h", 1'b0, serial_out);
					error_count++;
				end
				if (sync !== 1'b0) begin
					$display("ERROR sync: expected %h, got %h", 1'b0, sync);
					error_count++;
				end
			end
			if (word_q.size() - rd_ptr < 4) begin
				$display("fewer than 4 idle frames were received after reset");
				error_count++;
			end
			drain_idle();
		end
	endtask

	task automatic run_external_sequence();
		int n;
		int rnd;
		int gap;
		begin
			for (n = 0; n < 4; n++) begin
				drain_idle();
				trigger_in <= 1'b1;
				repeat (2) @(negedge clock);
				trigger_in <= 1'b0;
				expect_marker(marker_pattern(next_token), 4);
				next_token = (next_token + 1) % 4;
				// at least 3 slots plus a random extra
				rnd = $random(seed);
				gap = 24 + (rnd & 15);
				repeat (gap) @(negedge clock);
			end
		end
	endtask

	// two edges early in one slot before the strobe at position 6
	task automatic run_merged_edges();
		begin
			drain_idle();
			wait_for_frame();
			trigger_in <= 1'b1;
			@(negedge clock);
			trigger_in <= 1'b0;
			@(negedge clock);
			trigger_in <= 1'b1;
			@(negedge clock);
			trigger_in <= 1'b0;
			expect_marker(marker_pattern(next_token), 4);
			next_token = (next_token + 1) % 4;
			expect_idle(4);
		end
	endtask

	task automatic run_self_mode();
		int waited;
		int found;
		int last_cycle;
		int rnd;
		logic [7:0] w;
		int c;
		begin
			drain_idle();
			mode <= mode_self;
			waited = 0;
			found = 0;
			last_cycle = 0;
			while (found < 3 && waited < 4 * self_period + 64) begin
				@(negedge clock);
				waited++;
				// external edges must have no effect here
				rnd = $random(seed);
				trigger_in <= rnd[0];
				while (rd_ptr < word_q.size()) begin
					pop_word(w, c);
					if (w !== 8'h00) begin
						check_count++;
						if (w !== marker_pattern(next_token)) begin
							$display("ERROR status_word: expected %h, got %h",
								marker_pattern(next_token), w);
							error_count++;
						end
						if (found > 0 && c - last_cycle != self_period) begin
							$display("ERROR frame spacing: expected %h, got %h",
								self_period, c - last_cycle);
							error_count++;
						end
						next_token = (next_token + 1) % 4;
						last_cycle = c;
						found++;
					end
				end
			end
			if (found < 3) begin
				$display("timeout: only %0d self-triggered markers in %0d cycles", found, waited);
				timeout_count++;
			end
			trigger_in <= 1'b0;
		end
	endtask

	initial begin
		clock = 1'b0;
		reset1 = 1'b1;
		trigger_in = 1'b0;
		mode = mode_external;
		cycle = 0;
		error_count = 0;
		timeout_count = 0;
		check_count = 0;
		rx_error_count = 0;
		rx_check_count = 0;
		next_token = 0;
		rd_ptr = 0;
		rx_bits = 0;
		rx_shift = 8'h00;
		rx_sync = 1'b0;
		rx_cycle = 0;
		sync_expect = 1'b0;

		repeat (5) @(posedge clock);
		@(negedge clock);
		reset1 <= 1'b0;

		check_idle_after_reset();
		run_external_sequence();
		run_merged_edges();
		run_self_mode();

		$display("checks: %0d  errors: %0d  timeouts: %0d",
			check_count + rx_check_count, error_count + rx_error_count, timeout_count);
		if (error_count + rx_error_count + timeout_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
rtl/marker_pkg.sv
rtl/slot_pkg.sv
rtl/trig_input_conditioner.sv
rtl/slot_timer.sv
rtl/marker_sequencer.sv
rtl/word_serializer.sv
rtl/trigger_marker_top.sv
sim/trigger_marker_tb.sv

/* Makefile */
# Verilator simulation of the trigger marker generator

VERILATOR ?= verilator
TOP ?= trigger_marker_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# pass or fail is decided by the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
